// File: design/core_config_pkg.sv
`default_nettype none

package core_config_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and data types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    typedef logic [XLEN-1:0]       xlen_t;      // register data
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;  // csr address
    typedef logic [2*XLEN-1:0]     count_t;     // 64-bit event counter

    localparam int N_STORE  = 8;                // machine registers with storage
    localparam int STORE_W  = $clog2(N_STORE);
    localparam int N_CSR    = 24;               // every index, r_NONE included

    // event slots inside perf_counters
    localparam int N_EVENTS = 5;
    localparam int EV_CYCLE = 0;
    localparam int EV_INSTR = 1;
    localparam int EV_FLUSH = 2;
    localparam int EV_WAIT  = 3;
    localparam int EV_DECOD = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register indices
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [4:0] {
        r_MSTATUS, r_MIE, r_MTVEC, r_MSCRATCH, r_MEPC, r_MCAUSE, r_MTVAL, r_MIP,
        r_CYCLE, r_INSTR, r_FLUSH, r_WAIT, r_DECOD,
        r_CYCLEH, r_INSTRH, r_FLUSHH, r_WAITH, r_DECODH,
        r_MISA, r_MVENDORID, r_MARCHID, r_MIMPID, r_MHARTID, r_NONE
    } csr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t ADDR_MIE       = 12'h304;
    localparam csr_addr_t ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
    localparam csr_addr_t ADDR_MEPC      = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
    localparam csr_addr_t ADDR_MTVAL     = 12'h343;
    localparam csr_addr_t ADDR_MIP       = 12'h344;

    localparam csr_addr_t ADDR_CYCLE     = 12'hB00;  // 0xB01 (time) is not mapped
    localparam csr_addr_t ADDR_INSTR     = 12'hB02;
    localparam csr_addr_t ADDR_FLUSH     = 12'hB03;
    localparam csr_addr_t ADDR_WAIT      = 12'hB04;
    localparam csr_addr_t ADDR_DECOD     = 12'hB05;
    localparam csr_addr_t ADDR_CYCLEH    = 12'hB80;
    localparam csr_addr_t ADDR_INSTRH    = 12'hB82;
    localparam csr_addr_t ADDR_FLUSHH    = 12'hB83;
    localparam csr_addr_t ADDR_WAITH     = 12'hB84;
    localparam csr_addr_t ADDR_DECODH    = 12'hB85;

    localparam csr_addr_t ADDR_MISA      = 12'hF10;
    localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
    localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
    localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
    localparam csr_addr_t ADDR_MHARTID   = 12'hF14;

    // write masks, one per index in enum order
    localparam xlen_t CSR_WMASK [N_CSR] = '{
        32'h0000_1888, 32'h0000_0888, 32'hFFFF_FFFC, 32'hFFFF_FFFF,  // mstatus .. mscratch
        32'hFFFF_FFFC, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0888,  // mepc .. mip
        32'h0, 32'h0, 32'h0, 32'h0, 32'h0,                           // counter low words
        32'h0, 32'h0, 32'h0, 32'h0, 32'h0,                           // counter high words
        32'h0, 32'h0, 32'h0, 32'h0, 32'h0,                           // identification
        32'h0                                                        // r_NONE
    };

endpackage

`default_nettype wire

// File: design/perf_counters.sv
`default_nettype none
`timescale 1ns/10ps

module perf_counters
    import core_config_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  retire,   // one instruction retired
    input  logic  flush,    // pipeline flushed
    input  logic  stall,    // pipeline waiting
    input  logic  decode,   // one instruction decoded

    output xlen_t cycle_l,
    output xlen_t cycle_h,
    output xlen_t instr_l,
    output xlen_t instr_h,
    output xlen_t flush_l,
    output xlen_t flush_h,
    output xlen_t wait_l,
    output xlen_t wait_h,
    output xlen_t decod_l,
    output xlen_t decod_h
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // event vector
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [N_EVENTS-1:0] ev;                // increment request per counter
    count_t              cnt [N_EVENTS];    // the counters themselves

    always_comb begin
        ev           = '0;
        ev[EV_CYCLE] = 1'b1;                // cycle counter runs on every edge
        ev[EV_INSTR] = retire;
        ev[EV_FLUSH] = flush;
        ev[EV_WAIT]  = stall;
        ev[EV_DECOD] = decode;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // counting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        for (int i = 0; i < N_EVENTS; i++) begin
            if (!rst_n) begin
                cnt[i] <= '0;
            end else if (ev[i]) begin
                cnt[i] <= cnt[i] + count_t'(1);  // 64 bits, wrap is not a concern
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // split into csr words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // The csr block reads low and high halves at separate addresses, so a
    // software read of both halves may see a carry between the two reads
    assign cycle_l = cnt[EV_CYCLE][XLEN-1:0];
    assign cycle_h = cnt[EV_CYCLE][2*XLEN-1:XLEN];

    assign instr_l = cnt[EV_INSTR][XLEN-1:0];
    assign instr_h = cnt[EV_INSTR][2*XLEN-1:XLEN];

    assign flush_l = cnt[EV_FLUSH][XLEN-1:0];
    assign flush_h = cnt[EV_FLUSH][2*XLEN-1:XLEN];

    assign wait_l  = cnt[EV_WAIT][XLEN-1:0];
    assign wait_h  = cnt[EV_WAIT][2*XLEN-1:XLEN];

    assign decod_l = cnt[EV_DECOD][XLEN-1:0];
    assign decod_h = cnt[EV_DECOD][2*XLEN-1:XLEN];

endmodule

`default_nettype wire

// File: design/csr.sv
`default_nettype none
`timescale 1ns/10ps

module csr
    import core_config_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      we,       // write strobe
    input  csr_addr_t wa,
    input  xlen_t     wd,

    input  csr_addr_t ra,
    output xlen_t     rd,       // registered read data
    output logic      err,      // unmapped access

    input  xlen_t     cycle_l,
    input  xlen_t     cycle_h,
    input  xlen_t     instr_l,
    input  xlen_t     instr_h,
    input  xlen_t     flush_l,
    input  xlen_t     flush_h,
    input  xlen_t     wait_l,
    input  xlen_t     wait_h,
    input  xlen_t     decod_l,
    input  xlen_t     decod_h
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic csr_t csr_index(input csr_addr_t addr);
        csr_t idx;
        case (addr)
            ADDR_MSTATUS:   idx = r_MSTATUS;
            ADDR_MIE:       idx = r_MIE;
            ADDR_MTVEC:     idx = r_MTVEC;
            ADDR_MSCRATCH:  idx = r_MSCRATCH;
            ADDR_MEPC:      idx = r_MEPC;
            ADDR_MCAUSE:    idx = r_MCAUSE;
            ADDR_MTVAL:     idx = r_MTVAL;
            ADDR_MIP:       idx = r_MIP;
            ADDR_CYCLE:     idx = r_CYCLE;
            ADDR_INSTR:     idx = r_INSTR;
            ADDR_FLUSH:     idx = r_FLUSH;
            ADDR_WAIT:      idx = r_WAIT;
            ADDR_DECOD:     idx = r_DECOD;
            ADDR_CYCLEH:    idx = r_CYCLEH;
            ADDR_INSTRH:    idx = r_INSTRH;
            ADDR_FLUSHH:    idx = r_FLUSHH;
            ADDR_WAITH:     idx = r_WAITH;
            ADDR_DECODH:    idx = r_DECODH;
            ADDR_MISA:      idx = r_MISA;
            ADDR_MVENDORID: idx = r_MVENDORID;
            ADDR_MARCHID:   idx = r_MARCHID;
            ADDR_MIMPID:    idx = r_MIMPID;
            ADDR_MHARTID:   idx = r_MHARTID;
            default:        idx = r_NONE;
        endcase
        return idx;
    endfunction

    // masked merge, new bits under the mask and old bits elsewhere
    function automatic xlen_t update_bits(input xlen_t old_val, input xlen_t mask,
                                          input xlen_t data);
        return (data & mask) | (old_val & ~mask);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    xlen_t  csrs [N_STORE];     // machine registers
    csr_t   wid;
    csr_t   rid;
    csr_t   r_wid;              // index captured with the strobe
    xlen_t  r_wd;               // data captured with the strobe
    xlen_t  r_old;              // register value at capture time
    logic   write_state;        // set between capture and commit
    logic   wr_accept;
    xlen_t  rd_next;

    always_comb begin
        wid       = csr_index(wa);
        rid       = csr_index(ra);
        err       = (rid == r_NONE) || (we && wid == r_NONE);
        wr_accept = we && (wid != r_NONE) && !write_state;  // busy strobes are dropped
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write path, capture then commit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            r_wid <= wid;
            r_wd  <= wd;
            // counter and id indices have no storage, their old value is moot
            r_old <= (int'(wid) < N_STORE) ? csrs[wid[STORE_W-1:0]] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            write_state <= 1'b0;
            for (int i = 0; i < N_STORE; i++) begin
                csrs[i] <= '0;
            end
        end else if (write_state) begin
            if (int'(r_wid) < N_STORE) begin
                csrs[r_wid[STORE_W-1:0]] <= update_bits(r_old, CSR_WMASK[r_wid], r_wd);
            end
            write_state <= 1'b0;
        end else if (wr_accept) begin
            write_state <= 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (rid)
            r_CYCLE:  rd_next = cycle_l;
            r_CYCLEH: rd_next = cycle_h;
            r_INSTR:  rd_next = instr_l;
            r_INSTRH: rd_next = instr_h;
            r_FLUSH:  rd_next = flush_l;
            r_FLUSHH: rd_next = flush_h;
            r_WAIT:   rd_next = wait_l;
            r_WAITH:  rd_next = wait_h;
            r_DECOD:  rd_next = decod_l;
            r_DECODH: rd_next = decod_h;
            r_MISA, r_MVENDORID, r_MARCHID, r_MIMPID, r_MHARTID: begin
                rd_next = '0;   // identification reads as zero
            end
            default: begin
                rd_next = csrs[rid[STORE_W-1:0]];  // machine registers, r_NONE is never loaded
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd <= '0;
        end else if (rid != r_NONE) begin
            rd <= rd_next;  // unmapped ra keeps the last value
        end
    end

endmodule

`default_nettype wire

// File: design/csr_unit.sv
`default_nettype none
`timescale 1ns/10ps

module csr_unit
    import core_config_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      we,
    input  csr_addr_t wa,
    input  xlen_t     wd,
    input  csr_addr_t ra,
    output xlen_t     rd,
    output logic      err,

    input  logic      retire,   // core event pulses
    input  logic      flush,
    input  logic      stall,
    input  logic      decode
);

    // counter words between the two blocks
    xlen_t cycle_l, cycle_h;
    xlen_t instr_l, instr_h;
    xlen_t flush_l, flush_h;
    xlen_t wait_l,  wait_h;
    xlen_t decod_l, decod_h;

    perf_counters counters (
        .clk     (clk),
        .rst_n   (rst_n),
        .retire  (retire),
        .flush   (flush),
        .stall   (stall),
        .decode  (decode),
        .cycle_l (cycle_l),
        .cycle_h (cycle_h),
        .instr_l (instr_l),
        .instr_h (instr_h),
        .flush_l (flush_l),
        .flush_h (flush_h),
        .wait_l  (wait_l),
        .wait_h  (wait_h),
        .decod_l (decod_l),
        .decod_h (decod_h)
    );

    csr regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (we),
        .wa      (wa),
        .wd      (wd),
        .ra      (ra),
        .rd      (rd),
        .err     (err),
        .cycle_l (cycle_l),
        .cycle_h (cycle_h),
        .instr_l (instr_l),
        .instr_h (instr_h),
        .flush_l (flush_l),
        .flush_h (flush_h),
        .wait_l  (wait_l),
        .wait_h  (wait_h),
        .decod_l (decod_l),
        .decod_h (decod_h)
    );

endmodule

`default_nettype wire

// File: tb/csr_unit_assert.sv
`default_nettype none
`timescale 1ns/10ps

module csr_unit_assert
    import core_config_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      write_state,
    input csr_addr_t ra,
    input logic      err
);

    logic ra_mapped;

    assign ra_mapped = ra inside {ADDR_MSTATUS, ADDR_MIE, ADDR_MTVEC, ADDR_MSCRATCH,
                                  ADDR_MEPC, ADDR_MCAUSE, ADDR_MTVAL, ADDR_MIP,
                                  ADDR_CYCLE, ADDR_INSTR, ADDR_FLUSH, ADDR_WAIT, ADDR_DECOD,
                                  ADDR_CYCLEH, ADDR_INSTRH, ADDR_FLUSHH, ADDR_WAITH,
                                  ADDR_DECODH, ADDR_MISA, ADDR_MVENDORID, ADDR_MARCHID,
                                  ADDR_MIMPID, ADDR_MHARTID};

    // a captured write always commits on the very next edge
    write_state_one_edge: assert property (@(posedge clk) disable iff (!rst_n)
        write_state |=> !write_state)
        else $error("write_state stayed high for two edges");

    write_state_reset: assert property (@(posedge clk) !rst_n |=> !write_state)
        else $error("write_state not cleared by reset");

    err_on_unmapped_read: assert property (@(posedge clk) !ra_mapped |-> err)
        else $error("err low while ra is outside the map");

endmodule

bind csr csr_unit_assert checks (
    .clk         (clk),
    .rst_n       (rst_n),
    .write_state (write_state),
    .ra          (ra),
    .err         (err)
);

`default_nettype wire

// File: tb/csr_unit_tb.sv
`default_nettype none
`timescale 1ns/10ps

module csr_unit_tb
    import core_config_pkg::*;
();

    typedef enum logic [1:0] {OP_IDLE, OP_WRITE, OP_READ} op_t;

    typedef struct packed {
        op_t       op;
        csr_addr_t addr;
        xlen_t     data;
        logic      expect_err;
        logic [3:0] ev;         // {decode, stall, flush, retire}
    } entry_t;

    localparam csr_addr_t MACH_ADDR [8] = '{ADDR_MSTATUS, ADDR_MIE, ADDR_MTVEC, ADDR_MSCRATCH,
                                            ADDR_MEPC, ADDR_MCAUSE, ADDR_MTVAL, ADDR_MIP};
    localparam csr_addr_t CNT_LO [5] = '{ADDR_CYCLE, ADDR_INSTR, ADDR_FLUSH, ADDR_WAIT,
                                         ADDR_DECOD};
    localparam csr_addr_t CNT_HI [5] = '{ADDR_CYCLEH, ADDR_INSTRH, ADDR_FLUSHH, ADDR_WAITH,
                                         ADDR_DECODH};
    localparam csr_addr_t ID_ADDR [5] = '{ADDR_MISA, ADDR_MVENDORID, ADDR_MARCHID,
                                          ADDR_MIMPID, ADDR_MHARTID};

    logic      clk;
    logic      rst_n;
    logic      we;
    csr_addr_t wa;
    xlen_t     wd;
    csr_addr_t ra;
    xlen_t     rd;
    logic      err;
    logic      retire;
    logic      flush;
    logic      stall;
    logic      decode;

    entry_t      stim_q [$];        // stimulus table with one entry per cycle
    string       name_q [$];
    logic [31:0] rng;
    int          cycles;
    int          limit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    xlen_t  shadow [8];             // machine registers
    count_t model_cnt [5];          // cycle, instr, flush, wait, decod
    logic   pend;                   // model of write_state
    int     pend_slot;
    xlen_t  pend_data;
    xlen_t  pend_old;

    csr_unit UUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (we),
        .wa     (wa),
        .wd     (wd),
        .ra     (ra),
        .rd     (rd),
        .err    (err),
        .retire (retire),
        .flush  (flush),
        .stall  (stall),
        .decode (decode)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the stimulus table did not finish within %0d cycles", limit);
            $display("=== FAIL ===");
            $fatal(1, "run stopped by timeout");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 0..7 machine, 10..14 counter low, 20..24 counter high, 30 id, -1 unmapped
    function automatic int addr_slot(input csr_addr_t a);
        int s;
        s = -1;
        for (int i = 0; i < 8; i++) begin
            if (MACH_ADDR[i] == a) s = i;
        end
        for (int i = 0; i < 5; i++) begin
            if (CNT_LO[i] == a) s = 10 + i;
            if (CNT_HI[i] == a) s = 20 + i;
            if (ID_ADDR[i] == a) s = 30;
        end
        return s;
    endfunction

    function automatic xlen_t expected_read(input int s);
        if (s < 8) return shadow[s];
        if (s < 20) return model_cnt[s-10][31:0];
        if (s < 30) return model_cnt[s-20][63:32];
        return '0;                                  // identification space
    endfunction

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    // one clock edge of the model where a pending commit goes before any new capture
    task automatic advance_model(input entry_t e);
        int s;
        s = addr_slot(e.addr);
        if (pend) begin
            if (pend_slot < 8) begin
                shadow[pend_slot] = (pend_data & CSR_WMASK[pend_slot])
                                  | (pend_old & ~CSR_WMASK[pend_slot]);
            end
            pend = 1'b0;
        end else if (e.op == OP_WRITE && s >= 0) begin
            pend      = 1'b1;                       // strobes while pending are dropped
            pend_slot = s;
            pend_data = e.data;
            pend_old  = '0;
            if (s < 8) pend_old = shadow[s];
        end
        model_cnt[0] = model_cnt[0] + 64'd1;
        for (int i = 0; i < 4; i++) begin
            model_cnt[i+1] = model_cnt[i+1] + 64'(e.ev[i]);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus table construction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic push_entry(input op_t op, input csr_addr_t addr, input xlen_t data,
                              input logic expect_err, input string name);
        entry_t e;
        rng          = xorshift(rng);
        e.op         = op;
        e.addr       = addr;
        e.data       = data;
        e.expect_err = expect_err;
        e.ev         = rng[3:0];                    // random event pulses
        stim_q.push_back(e);
        name_q.push_back(name);
    endtask

    task automatic write_then_idle(input csr_addr_t addr, input xlen_t data,
                                   input logic expect_err, input string name);
        push_entry(OP_WRITE, addr, data, expect_err, name);
        push_entry(OP_IDLE, '0, '0, 1'b0, {name, " idle"});
    endtask

    task automatic read_once(input csr_addr_t addr, input logic expect_err, input string name);
        push_entry(OP_READ, addr, '0, expect_err, name);
    endtask

    task automatic build_stimulus();
        for (int i = 0; i < 8; i++) begin
            read_once(MACH_ADDR[i], 1'b0, "reset value");
        end
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 8; i++) begin
                rng = xorshift(rng);
                write_then_idle(MACH_ADDR[i], rng, 1'b0, "masked write");
                read_once(MACH_ADDR[i], 1'b0, "masked readback");
            end
        end
        for (int i = 0; i < 5; i++) begin
            write_then_idle(CNT_LO[i], 32'hFFFF_FFFF, 1'b0, "counter write");
            read_once(CNT_LO[i], 1'b0, "counter after write");
            write_then_idle(ID_ADDR[i], 32'hFFFF_FFFF, 1'b0, "id write");
            read_once(ID_ADDR[i], 1'b0, "id read");
        end
        for (int i = 0; i < 5; i++) begin
            read_once(CNT_LO[i], 1'b0, "counter low");
            read_once(CNT_HI[i], 1'b0, "counter high");
        end
        // a nonzero rd ahead of the unmapped reads shows that rd is held
        read_once(ADDR_CYCLE, 1'b0, "cycle before unmapped");
        read_once(12'h301, 1'b1, "unmapped read");
        read_once(12'hB01, 1'b1, "unmapped time read");
        write_then_idle(12'h7C0, 32'hFFFF_FFFF, 1'b1, "unmapped write");
        for (int i = 0; i < 8; i++) begin
            read_once(MACH_ADDR[i], 1'b0, "after unmapped write");
        end
        push_entry(OP_WRITE, ADDR_MSCRATCH, 32'h1234_5678, 1'b0, "first write");
        write_then_idle(ADDR_MSCRATCH, 32'hDEAD_BEEF, 1'b0, "dropped same reg");
        read_once(ADDR_MSCRATCH, 1'b0, "readback after drop");
        push_entry(OP_WRITE, ADDR_MEPC, 32'hCAFE_F00C, 1'b0, "first write");
        write_then_idle(ADDR_MTVAL, 32'h0BAD_0BAD, 1'b0, "dropped other reg");
        read_once(ADDR_MTVAL, 1'b0, "dropped reg unchanged");
        read_once(ADDR_MEPC, 1'b0, "accepted reg updated");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        entry_t e;
        int     s;
        xlen_t  exp_rd;
        rst_n  = 1'b0;
        we     = 1'b0;
        wa     = '0;
        wd     = '0;
        ra     = ADDR_MSTATUS;
        retire = 1'b0;
        flush  = 1'b0;
        stall  = 1'b0;
        decode = 1'b0;
        cycles = 0;
        limit  = 0;
        rng    = 32'd26708;
        pend   = 1'b0;
        pend_slot = 0;
        pend_data = '0;
        pend_old  = '0;
        exp_rd = '0;                                // rd clears in reset
        for (int i = 0; i < 8; i++) begin
            shadow[i] = '0;
        end
        for (int i = 0; i < 5; i++) begin
            model_cnt[i] = '0;
        end
        build_stimulus();
        limit = stim_q.size() + 8 + 20;
        repeat (8) @(posedge clk);
        #5 rst_n = 1'b1;
        check_value("reset rd", exp_rd, rd);
        for (int i = 0; i < stim_q.size(); i++) begin
            e  = stim_q[i];
            we = (e.op == OP_WRITE);
            wa = e.addr;
            wd = e.data;
            ra = (e.op == OP_READ) ? e.addr : ADDR_MSTATUS;
            {decode, stall, flush, retire} = e.ev;
            #1;
            check_value({name_q[i], " err"}, xlen_t'(e.expect_err), xlen_t'(err));
            s = addr_slot(ra);
            if (s >= 0) exp_rd = expected_read(s);  // unmapped ra keeps rd
            @(posedge clk);
            advance_model(e);
            #5;
            check_value({name_q[i], " rd"}, exp_rd, rd);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
design/core_config_pkg.sv
design/perf_counters.sv
design/csr.sv
design/csr_unit.sv
tb/csr_unit_assert.sv
tb/csr_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the csr_unit testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module csr_unit_tb -f files.f || { echo "build failed"; exit 1; }

out="$(./obj_dir/Vcsr_unit_tb 2>&1)"
echo "$out"

grep -qx "=== PASS ===" <<< "$out" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
